//--- include/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Core address and data path
`define DC_ADDR_WIDTH 32
`define DC_DATA_WIDTH 64

// Cache geometry
`define DC_LINE_BYTES 64  // One line is one full AXI burst
`define DC_SETS       16
`define DC_WAYS       4

// Data beats per line on the memory port
`define DC_BEATS      8

`endif

//--- logic/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    localparam int byte_bits   = $clog2(`DC_DATA_WIDTH / 8);
    localparam int offset_bits = $clog2(`DC_LINE_BYTES);
    localparam int index_bits  = $clog2(`DC_SETS);
    localparam int tag_bits    = `DC_ADDR_WIDTH - index_bits - offset_bits;

    typedef logic [`DC_ADDR_WIDTH-1:0]     addr_t;
    typedef logic [tag_bits-1:0]           tag_t;
    typedef logic [index_bits-1:0]         index_t;
    typedef logic [$clog2(`DC_BEATS)-1:0]  word_sel_t;
    typedef logic [byte_bits-1:0]          byte_sel_t;
    typedef logic [$clog2(`DC_WAYS)-1:0]   way_t;
    typedef logic [`DC_DATA_WIDTH-1:0]     word_t;
    typedef logic [8*`DC_LINE_BYTES-1:0]   line_t;

    // Access size code as the core sends it
    typedef logic [2:0] size_t;
    localparam size_t size_byte  = 3'd1;
    localparam size_t size_half  = 3'd2;
    localparam size_t size_word  = 3'd4;
    localparam size_t size_dword = 3'd7;

    typedef enum logic [3:0] {
        st_idle,
        st_lookup,       // Registered lookup result is valid here
        st_respond,
        st_evict_start,
        st_writeback,
        st_fill_start,
        st_fill_wait,
        st_install
    } ctrl_state_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[`DC_ADDR_WIDTH-1 -: tag_bits];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[offset_bits +: index_bits];
    endfunction

    function automatic word_sel_t addr_word(addr_t a);
        return a[byte_bits +: $bits(word_sel_t)];
    endfunction

endpackage

//--- logic/axi_burst_pkg.sv
`include "dcache_settings.svh"

package axi_burst_pkg;

    typedef logic [1:0] burst_t;
    typedef logic [7:0] len_t;
    typedef logic [2:0] asize_t;
    typedef logic [1:0] resp_t;

    localparam burst_t burst_incr = 2'b01;

    // Whole line per burst, one data word per beat
    localparam len_t   line_len  = len_t'(`DC_BEATS - 1);
    localparam asize_t beat_size = asize_t'($clog2(`DC_DATA_WIDTH / 8));

endpackage

//--- logic/dcache_array.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_array
    import dcache_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       lookup,
    input  logic       write_word,
    input  logic       install_line,
    input  addr_t      address,
    input  way_t       access_way,
    input  logic [7:0] byte_mask,
    input  word_t      store_data,
    input  line_t      fill_line,
    output logic       hit,
    output way_t       hit_way,
    output word_t      read_word,
    output logic       victim_valid,
    output logic       victim_dirty,
    output tag_t       victim_tag,
    output line_t      victim_line
);

    tag_t               tags [`DC_SETS][`DC_WAYS];
    line_t              lines [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0] valid_bits [`DC_SETS];
    logic [`DC_WAYS-1:0] dirty_bits [`DC_SETS];

    index_t    idx;
    index_t    idx_q;   // Set of the last lookup, used for victim reads
    tag_t      tag;
    word_sel_t word;
    logic      match;
    way_t      match_way;
    way_t      free_way;

    assign idx  = addr_index(address);
    assign tag  = addr_tag(address);
    assign word = addr_word(address);

    always_comb begin
        match     = 1'b0;
        match_way = '0;
        free_way  = '0;
        // Walk down so the lowest invalid way is the one left standing
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!valid_bits[idx][w])
                free_way = way_t'(w);
            if (valid_bits[idx][w] && tags[idx][w] == tag) begin
                match     = 1'b1;
                match_way = way_t'(w);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            hit <= 1'b0;
        else if (lookup)
            hit <= match;
    end

    // On a miss hit_way names the first free way as a fill candidate
    always_ff @(posedge clock) begin
        if (lookup) begin
            hit_way   <= match ? match_way : free_way;
            read_word <= lines[idx][match_way][{word, 6'd0} +: `DC_DATA_WIDTH];
            idx_q     <= idx;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
            end
        end else if (install_line) begin
            valid_bits[idx][access_way] <= 1'b1;
            dirty_bits[idx][access_way] <= 1'b0;  // Fresh copy of memory
        end else if (write_word) begin
            dirty_bits[idx][access_way] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (install_line) begin
            lines[idx][access_way] <= fill_line;
            tags[idx][access_way]  <= tag;
        end else if (write_word) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_mask[b])
                    lines[idx][access_way][{word, 3'(b), 3'd0} +: 8] <= store_data[8*b +: 8];
            end
        end
    end

    assign victim_valid = valid_bits[idx_q][access_way];
    assign victim_dirty = dirty_bits[idx_q][access_way];
    assign victim_tag   = tags[idx_q][access_way];
    assign victim_line  = lines[idx_q][access_way];

endmodule

//--- logic/load_store_align.sv
`timescale 1ns/1ps

module load_store_align
    import dcache_pkg::*;
(
    input  addr_t      address,
    input  size_t      data_size,
    input  logic       load_sign,
    input  word_t      read_word,
    input  word_t      data_input,
    output word_t      data_out,
    output logic [7:0] byte_mask,
    output word_t      store_data
);

    byte_sel_t  offset;
    word_t      shifted;
    logic [7:0] size_mask;

    assign offset  = address[$bits(byte_sel_t)-1:0];
    assign shifted = read_word >> {offset, 3'd0};  // Addressed bytes moved to bit 0

    always_comb begin
        case (data_size)
            size_byte:  data_out = {{56{load_sign & shifted[7]}}, shifted[7:0]};
            size_half:  data_out = {{48{load_sign & shifted[15]}}, shifted[15:0]};
            size_word:  data_out = {{32{load_sign & shifted[31]}}, shifted[31:0]};
            size_dword: data_out = shifted;
            default:    data_out = '0;
        endcase
    end

    always_comb begin
        case (data_size)
            size_byte:  size_mask = 8'h01;
            size_half:  size_mask = 8'h03;
            size_word:  size_mask = 8'h0f;
            size_dword: size_mask = 8'hff;
            default:    size_mask = 8'h00;  // Unknown size writes nothing
        endcase
    end

    // Aligned requests never push the mask past byte 7
    assign byte_mask  = size_mask << offset;
    assign store_data = data_input << {offset, 3'd0};

endmodule

//--- logic/dcache_controller.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_controller
    import dcache_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  read_enable,
    input  logic  write_enable,
    input  addr_t address,
    input  logic  hit,
    input  way_t  hit_way,
    input  logic  victim_valid,
    input  logic  victim_dirty,
    input  tag_t  victim_tag,
    output logic  lookup,
    output logic  write_word,
    output logic  install_line,
    output way_t  access_way,
    output logic  fill_start,
    output logic  wb_start,
    output addr_t mem_address,
    input  logic  fill_done,
    input  logic  wb_done,
    output logic  send_enable
);

    ctrl_state_t state;
    way_t        victim_way;
    way_t        rr_count;
    logic        request;

    assign request = read_enable | write_enable;

    assign lookup       = (state == st_idle) && request;
    assign write_word   = (state == st_lookup) && hit && write_enable;  // Lands with send_enable
    assign install_line = (state == st_install);
    assign fill_start   = (state == st_fill_start);
    assign wb_start     = (state == st_evict_start) && victim_dirty;

    // In lookup the array reports either the hit way or the first free way
    assign access_way = (state == st_lookup) ? hit_way : victim_way;

    always_comb begin
        if (wb_start)
            mem_address = {victim_tag, addr_index(address), offset_bits'(0)};
        else
            mem_address = {address[`DC_ADDR_WIDTH-1:offset_bits], offset_bits'(0)};
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= st_idle;
            send_enable <= 1'b0;
            rr_count    <= '0;
        end else begin
            send_enable <= 1'b0;
            case (state)
                st_idle: begin
                    if (request)
                        state <= st_lookup;
                end
                st_lookup: begin
                    if (hit) begin
                        send_enable <= 1'b1;
                        state       <= st_respond;
                    end else begin
                        if (victim_valid)
                            rr_count <= rr_count + 1'b1;  // Set is full so round robin is used
                        state <= st_evict_start;
                    end
                end
                st_respond:     state <= st_idle;  // Core drops its request now
                st_evict_start: state <= victim_dirty ? st_writeback : st_fill_start;
                st_writeback: begin
                    if (wb_done)
                        state <= st_fill_start;
                end
                st_fill_start:  state <= st_fill_wait;
                st_fill_wait: begin
                    if (fill_done)
                        state <= st_install;
                end
                st_install:     state <= st_idle;  // Retry the lookup which now hits
                default:        state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_lookup && !hit)
            victim_way <= victim_valid ? rr_count : hit_way;
    end

endmodule

//--- logic/axi_line_port.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module axi_line_port
    import dcache_pkg::*;
    import axi_burst_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       fill_start,
    input  logic       wb_start,
    input  addr_t      mem_address,
    input  line_t      victim_line,
    output line_t      fill_line,
    output logic       fill_done,
    output logic       wb_done,
    output logic       m_axi_arvalid,
    input  logic       m_axi_arready,
    output addr_t      m_axi_araddr,
    output len_t       m_axi_arlen,
    output asize_t     m_axi_arsize,
    output burst_t     m_axi_arburst,
    input  logic       m_axi_rvalid,
    output logic       m_axi_rready,
    input  word_t      m_axi_rdata,
    input  logic       m_axi_rlast,
    output logic       m_axi_awvalid,
    input  logic       m_axi_awready,
    output addr_t      m_axi_awaddr,
    output len_t       m_axi_awlen,
    output asize_t     m_axi_awsize,
    output burst_t     m_axi_awburst,
    output logic       m_axi_wvalid,
    input  logic       m_axi_wready,
    output word_t      m_axi_wdata,
    output logic [7:0] m_axi_wstrb,
    output logic       m_axi_wlast,
    input  logic       m_axi_bvalid,
    output logic       m_axi_bready,
    input  resp_t      m_axi_bresp
);

    addr_t     burst_addr;
    line_t     line_buf;   // Fill target, or the latched victim on write-back
    word_sel_t beat;

    assign m_axi_araddr  = burst_addr;
    assign m_axi_arlen   = line_len;
    assign m_axi_arsize  = beat_size;
    assign m_axi_arburst = burst_incr;
    assign m_axi_awaddr  = burst_addr;
    assign m_axi_awlen   = line_len;
    assign m_axi_awsize  = beat_size;
    assign m_axi_awburst = burst_incr;
    assign m_axi_wdata   = line_buf[{beat, 6'd0} +: `DC_DATA_WIDTH];
    assign m_axi_wstrb   = 8'hff;
    assign m_axi_wlast   = m_axi_wvalid && beat == word_sel_t'(`DC_BEATS - 1);
    assign fill_line     = line_buf;

    always_ff @(posedge clock) begin
        if (reset) begin
            m_axi_arvalid <= 1'b0;
            m_axi_rready  <= 1'b0;
            m_axi_awvalid <= 1'b0;
            m_axi_wvalid  <= 1'b0;
            m_axi_bready  <= 1'b0;
            fill_done     <= 1'b0;
            wb_done       <= 1'b0;
            beat          <= '0;
        end else begin
            fill_done <= 1'b0;
            wb_done   <= 1'b0;
            if (fill_start || wb_start)
                beat <= '0;
            if (fill_start) begin
                m_axi_arvalid <= 1'b1;
                m_axi_rready  <= 1'b1;  // Held for the whole fill
            end
            if (m_axi_arvalid && m_axi_arready)
                m_axi_arvalid <= 1'b0;
            if (m_axi_rvalid && m_axi_rready) begin
                beat <= beat + 1'b1;
                if (m_axi_rlast) begin
                    m_axi_rready <= 1'b0;
                    fill_done    <= 1'b1;
                end
            end
            if (wb_start)
                m_axi_awvalid <= 1'b1;
            if (m_axi_awvalid && m_axi_awready) begin
                m_axi_awvalid <= 1'b0;
                m_axi_wvalid  <= 1'b1;
            end
            if (m_axi_wvalid && m_axi_wready) begin
                beat <= beat + 1'b1;
                if (m_axi_wlast) begin
                    m_axi_wvalid <= 1'b0;
                    m_axi_bready <= 1'b1;
                end
            end
            if (m_axi_bvalid && m_axi_bready) begin
                m_axi_bready <= 1'b0;  // Response code is not checked
                wb_done      <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill_start || wb_start)
            burst_addr <= mem_address;
        if (wb_start)
            line_buf <= victim_line;
        else if (m_axi_rvalid && m_axi_rready)
            line_buf[{beat, 6'd0} +: `DC_DATA_WIDTH] <= m_axi_rdata;
    end

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
    import axi_burst_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       read_enable,
    input  logic       write_enable,
    input  logic       load_sign,
    input  addr_t      address,
    input  size_t      data_size,
    input  word_t      data_input,
    output word_t      data_out,
    output logic       send_enable,
    output logic       m_axi_arvalid,
    input  logic       m_axi_arready,
    output addr_t      m_axi_araddr,
    output len_t       m_axi_arlen,
    output asize_t     m_axi_arsize,
    output burst_t     m_axi_arburst,
    input  logic       m_axi_rvalid,
    output logic       m_axi_rready,
    input  word_t      m_axi_rdata,
    input  logic       m_axi_rlast,
    output logic       m_axi_awvalid,
    input  logic       m_axi_awready,
    output addr_t      m_axi_awaddr,
    output len_t       m_axi_awlen,
    output asize_t     m_axi_awsize,
    output burst_t     m_axi_awburst,
    output logic       m_axi_wvalid,
    input  logic       m_axi_wready,
    output word_t      m_axi_wdata,
    output logic [7:0] m_axi_wstrb,
    output logic       m_axi_wlast,
    input  logic       m_axi_bvalid,
    output logic       m_axi_bready,
    input  resp_t      m_axi_bresp
);

    // Controller to array
    logic lookup;
    logic write_word;
    logic install_line;
    way_t access_way;

    // Array results
    logic  hit;
    way_t  hit_way;
    word_t read_word;
    logic  victim_valid;
    logic  victim_dirty;
    tag_t  victim_tag;
    line_t victim_line;

    // Byte lane alignment
    logic [7:0] byte_mask;
    word_t      store_data;

    // Memory port handshake
    logic  fill_start;
    logic  wb_start;
    addr_t mem_address;
    line_t fill_line;
    logic  fill_done;
    logic  wb_done;

    dcache_controller controller (.*);

    dcache_array array (.*);

    load_store_align align (.*);

    axi_line_port line_port (.*);

endmodule

//--- verification/dcache_asserts.sv
`timescale 1ns/1ps

module dcache_asserts
    import dcache_pkg::*;
(
    input logic  clock,
    input logic  reset,
    input logic  send_enable,
    input logic  m_axi_arvalid,
    input logic  m_axi_arready,
    input addr_t m_axi_araddr,
    input logic  m_axi_awvalid,
    input logic  m_axi_awready,
    input addr_t m_axi_awaddr,
    input logic  m_axi_wvalid,
    input logic  m_axi_wready,
    input word_t m_axi_wdata,
    input logic  m_axi_wlast
);

    int failure_count = 0;  // Assertion failures so far

    ar_held: assert property (@(posedge clock) disable iff (reset)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
    else begin
        $error("arvalid dropped or araddr changed before arready");
        failure_count++;
    end

    aw_held: assert property (@(posedge clock) disable iff (reset)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
    else begin
        $error("awvalid dropped or awaddr changed before awready");
        failure_count++;
    end

    // Write beat payload must not move while the memory stalls
    w_held: assert property (@(posedge clock) disable iff (reset)
        m_axi_wvalid && !m_axi_wready
        |=> m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wlast))
    else begin
        $error("wvalid dropped or W payload changed before wready");
        failure_count++;
    end

    send_pulse: assert property (@(posedge clock) disable iff (reset)
        send_enable |=> !send_enable)
    else begin
        $error("send_enable lasted more than one cycle");
        failure_count++;
    end

    one_burst: assert property (@(posedge clock) disable iff (reset)
        !(m_axi_arvalid && m_axi_awvalid))
    else begin
        $error("arvalid and awvalid high together");
        failure_count++;
    end

endmodule

//--- verification/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb
    import dcache_pkg::*;
    import axi_burst_pkg::*;
();

    logic  clock = 1'b0;
    logic  reset = 1'b1;
    logic  read_enable;
    logic  write_enable;
    logic  load_sign;
    addr_t address;
    size_t data_size;
    word_t data_input;
    word_t data_out;
    logic  send_enable;

    logic       m_axi_arvalid;
    logic       m_axi_arready = 1'b0;
    addr_t      m_axi_araddr;
    len_t       m_axi_arlen;
    asize_t     m_axi_arsize;
    burst_t     m_axi_arburst;
    logic       m_axi_rvalid = 1'b0;
    logic       m_axi_rready;
    word_t      m_axi_rdata = '0;
    logic       m_axi_rlast = 1'b0;
    logic       m_axi_awvalid;
    logic       m_axi_awready = 1'b0;
    addr_t      m_axi_awaddr;
    len_t       m_axi_awlen;
    asize_t     m_axi_awsize;
    burst_t     m_axi_awburst;
    logic       m_axi_wvalid;
    logic       m_axi_wready = 1'b0;
    word_t      m_axi_wdata;
    logic [7:0] m_axi_wstrb;
    logic       m_axi_wlast;
    logic       m_axi_bvalid = 1'b0;
    logic       m_axi_bready;
    resp_t      m_axi_bresp = '0;

    logic [7:0] mem [addr_t];     // Memory behind the AXI port
    logic [7:0] shadow [addr_t];  // Contents as the core should see them
    size_t      size_list [4] = '{size_byte, size_half, size_word, size_dword};

    logic  rd_active = 1'b0;
    logic  wr_active = 1'b0;
    logic  b_pending = 1'b0;
    logic  r_take;
    int    rd_beat;
    int    next_beat;
    int    wr_beat;
    addr_t rd_addr;
    addr_t wr_addr;
    addr_t last_araddr;
    addr_t last_awaddr;
    int    ar_count = 0;
    int    aw_count = 0;
    int    loads_checked = 0;

    dcache_top uut (.*);

    bind dcache_top dcache_asserts protocol_checks (.*);

    always #2 clock = ~clock;

    // Untouched memory holds a hash of the byte address
    function automatic logic [7:0] fill_byte(addr_t a);
        return 8'((a * 32'h9e37_79b1) >> 24);
    endfunction

    function automatic logic [7:0] mem_byte(addr_t a);
        return mem.exists(a) ? mem[a] : fill_byte(a);
    endfunction

    function automatic logic [7:0] shadow_byte(addr_t a);
        return shadow.exists(a) ? shadow[a] : fill_byte(a);
    endfunction

    function automatic word_t stored_word(addr_t a, logic from_shadow);
        word_t w;
        for (int i = 0; i < 8; i++)
            w[8*i +: 8] = from_shadow ? shadow_byte(a + addr_t'(i)) : mem_byte(a + addr_t'(i));
        return w;
    endfunction

    function automatic int size_bytes(size_t sz);
        case (sz)
            size_byte: return 1;
            size_half: return 2;
            size_word: return 4;
            default:   return 8;
        endcase
    endfunction

    // Expected little endian load value taken from the shadow memory
    function automatic word_t expected_load(addr_t a, size_t sz, logic sgn);
        word_t v;
        int    n;
        v = '0;
        n = size_bytes(sz);
        for (int i = 0; i < n; i++)
            v[8*i +: 8] = shadow_byte(a + addr_t'(i));
        if (sgn && n < 8 && v[8*n-1]) begin
            for (int i = n; i < 8; i++)
                v[8*i +: 8] = 8'hff;
        end
        return v;
    endfunction

    task automatic apply_store(input addr_t a, input size_t sz, input word_t d);
        for (int i = 0; i < size_bytes(sz); i++)
            shadow[a + addr_t'(i)] = d[8*i +: 8];
    endtask

    task automatic report_failure();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("ERR t=%0t ns %s got %h expected %h", $time, name, got, expected);
            report_failure();
        end
    endtask

    // Read side of the memory model with random stalls
    always @(posedge clock) begin
        r_take    = m_axi_rvalid && m_axi_rready;
        next_beat = r_take ? rd_beat + 1 : rd_beat;
        if (reset) begin
            m_axi_arready <= 1'b0;
            m_axi_rvalid  <= 1'b0;
            m_axi_rlast   <= 1'b0;
            rd_active     <= 1'b0;
        end else begin
            m_axi_arready <= !rd_active && ($urandom % 2 == 0);
            if (m_axi_arvalid && m_axi_arready) begin
                check_value("m_axi_arlen", 64'(m_axi_arlen), 64'(`DC_BEATS - 1));
                check_value("m_axi_arburst", 64'(m_axi_arburst), 64'(2'b01));
                check_value("m_axi_arsize", 64'(m_axi_arsize), 64'(3));
                check_value("m_axi_araddr offset", 64'(m_axi_araddr[5:0]), 64'(0));
                rd_addr     <= m_axi_araddr;
                last_araddr <= m_axi_araddr;
                rd_active   <= 1'b1;
                next_beat   = 0;
                ar_count++;
            end else if (r_take && rd_beat == `DC_BEATS - 1) begin
                m_axi_rvalid <= 1'b0;
                m_axi_rlast  <= 1'b0;
                rd_active    <= 1'b0;
            end else if (rd_active && (!m_axi_rvalid || r_take)) begin
                m_axi_rvalid <= ($urandom % 4 != 0);
                m_axi_rdata  <= stored_word(rd_addr + addr_t'(8 * next_beat), 1'b0);
                m_axi_rlast  <= (next_beat == `DC_BEATS - 1);
            end
            rd_beat <= next_beat;
        end
    end

    // Write side checks every beat against the shadow copy of the evicted line
    always @(posedge clock) begin
        if (reset) begin
            m_axi_awready <= 1'b0;
            m_axi_wready  <= 1'b0;
            m_axi_bvalid  <= 1'b0;
            wr_active     <= 1'b0;
            b_pending     <= 1'b0;
        end else begin
            m_axi_awready <= !wr_active && !b_pending && ($urandom % 2 == 0);
            m_axi_wready  <= wr_active && ($urandom % 3 != 0);
            if (m_axi_awvalid && m_axi_awready) begin
                check_value("m_axi_awlen", 64'(m_axi_awlen), 64'(`DC_BEATS - 1));
                check_value("m_axi_awburst", 64'(m_axi_awburst), 64'(2'b01));
                check_value("m_axi_awsize", 64'(m_axi_awsize), 64'(3));
                check_value("m_axi_awaddr offset", 64'(m_axi_awaddr[5:0]), 64'(0));
                wr_addr     <= m_axi_awaddr;
                last_awaddr <= m_axi_awaddr;
                wr_active   <= 1'b1;
                wr_beat     <= 0;
                aw_count++;
            end
            if (m_axi_wvalid && m_axi_wready) begin
                check_value("m_axi_wlast", 64'(m_axi_wlast), 64'(wr_beat == `DC_BEATS - 1));
                check_value("m_axi_wstrb", 64'(m_axi_wstrb), 64'(8'hff));
                check_value("m_axi_wdata", m_axi_wdata,
                            stored_word(wr_addr + addr_t'(8 * wr_beat), 1'b1));
                for (int i = 0; i < 8; i++)
                    mem[wr_addr + addr_t'(8 * wr_beat + i)] = m_axi_wdata[8*i +: 8];
                wr_beat <= wr_beat + 1;
                if (m_axi_wlast) begin
                    wr_active <= 1'b0;
                    b_pending <= 1'b1;
                end
            end
            if (m_axi_bvalid && m_axi_bready) begin
                m_axi_bvalid <= 1'b0;
                b_pending    <= 1'b0;
            end else if (b_pending && !m_axi_bvalid) begin
                m_axi_bvalid <= ($urandom % 2 == 0);
            end
        end
    end

    // Loads are compared here and stores update the shadow
    always @(posedge clock) begin
        if (!reset && send_enable && read_enable) begin
            check_value("data_out", data_out, expected_load(address, data_size, load_sign));
            loads_checked++;
        end else if (!reset && send_enable && write_enable) begin
            apply_store(address, data_size, data_input);
        end
    end

    // Protocol checks from the bound assertion module
    always @(posedge clock) begin
        if (uut.protocol_checks.failure_count != 0) begin
            $display("Protocol assertion failed before t=%0t ns", $time);
            report_failure();
        end
    end

    task automatic access(input logic is_store, input addr_t a, input size_t sz,
                          input logic sgn, output int latency);
        @(posedge clock);
        read_enable  <= !is_store;
        write_enable <= is_store;
        address      <= a;
        data_size    <= sz;
        load_sign    <= sgn;
        data_input   <= {$urandom, $urandom};
        latency = 0;
        do begin
            @(posedge clock);
            latency++;
            if (latency > 3000) begin
                $display("Timeout: no send_enable within 3000 cycles for address %h", a);
                report_failure();
            end
        end while (!send_enable);
        read_enable  <= 1'b0;  // Request dropped right after the pulse
        write_enable <= 1'b0;
    endtask

    task automatic load_hit(input addr_t a, input size_t sz, input logic sgn);
        int lat;
        int ar_before;
        ar_before = ar_count;
        access(1'b0, a, sz, sgn, lat);
        check_value("ar request count on hit", 64'(ar_count), 64'(ar_before));
        check_value("send_enable latency", 64'(lat - 1), 64'(2));
    endtask

    initial begin
        int    lat;
        int    ar_before;
        int    aw_before;
        addr_t a;
        size_t sz;
        void'($urandom(32'hda09_d8bc));
        read_enable  = 1'b0;
        write_enable = 1'b0;
        load_sign    = 1'b0;
        address      = '0;
        data_size    = size_dword;
        data_input   = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        check_value("send_enable after reset", 64'(send_enable), 64'(0));
        check_value("AXI valid and ready after reset", 64'({m_axi_arvalid, m_axi_awvalid,
                    m_axi_wvalid, m_axi_wlast, m_axi_rready, m_axi_bready}), 64'(0));

        // First load of each size and sign misses into its own line
        for (int k = 0; k < 8; k++) begin
            sz = size_list[2'(k)];
            a  = 32'h0001_0000 + addr_t'(64 * k + 8 * k + 8 - size_bytes(sz));
            ar_before = ar_count;
            access(1'b0, a, sz, 1'(k / 4), lat);
            check_value("ar request count on miss", 64'(ar_count), 64'(ar_before + 1));
            check_value("m_axi_araddr", 64'(last_araddr), 64'({a[31:6], 6'd0}));
        end

        for (int k = 0; k < 8; k++) begin
            for (int j = 0; j < 4; j++) begin
                a = 32'h0001_0000 + addr_t'(64 * k + 8 * j + 8 - size_bytes(size_list[2'(j)]));
                load_hit(a, size_list[2'(j)], 1'($urandom % 2));
            end
        end

        // Stores of every size followed by loads that overlap them
        for (int k = 0; k < 16; k++) begin
            sz = size_list[2'(k)];
            a  = 32'h0001_0000 + addr_t'(64 * (k % 8))
                 + (addr_t'($urandom % 64) & ~addr_t'(size_bytes(sz) - 1));
            access(1'b1, a, sz, 1'b0, lat);
            for (int j = 0; j < 4; j++)
                load_hit(a & ~addr_t'(size_bytes(size_list[2'(j)]) - 1), size_list[2'(j)],
                         1'($urandom % 2));
        end

        // Five dirty lines in set 12 so the fifth evicts way 0 with the first line
        for (int k = 0; k < 5; k++) begin
            aw_before = aw_count;
            access(1'b1, 32'h0002_0300 + addr_t'(32'h400 * k), size_dword, 1'b0, lat);
            check_value("aw request count", 64'(aw_count), 64'(aw_before + (k == 4 ? 1 : 0)));
        end
        check_value("m_axi_awaddr", 64'(last_awaddr), 64'(32'h0002_0300));
        for (int k = 0; k < 5; k++)
            access(1'b0, 32'h0002_0300 + addr_t'(32'h400 * k), size_dword, 1'b0, lat);

        // Random loads and stores over three sets and six tags
        for (int n = 0; n < 600; n++) begin
            sz = size_list[2'($urandom % 4)];
            a  = 32'h0004_0000 + addr_t'(32'h400 * ($urandom % 6) + 64 * ($urandom % 3))
                 + (addr_t'($urandom % 64) & ~addr_t'(size_bytes(sz) - 1));
            access(1'($urandom % 2), a, sz, 1'($urandom % 2), lat);
        end

        $display("Checked %0d loads, %0d fills, %0d write-backs",
                 loads_checked, ar_count, aw_count);
        if (uut.protocol_checks.failure_count != 0) begin
            $display("Protocol assertions failed %0d times", uut.protocol_checks.failure_count);
            report_failure();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- project.f
+incdir+include
logic/dcache_pkg.sv
logic/axi_burst_pkg.sv
logic/dcache_array.sv
logic/load_store_align.sv
logic/dcache_controller.sv
logic/axi_line_port.sv
logic/dcache_top.sv
verification/dcache_asserts.sv
verification/dcache_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module dcache_tb

sim:
	verilator --binary --timing --assert -f project.f --top-module dcache_tb -o Vdcache_tb
	./obj_dir/Vdcache_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
